// File: tb.f
pulse_types_pkg.sv
pulse_mem_pkg.sv
pulse_mem_if.sv
pulse_queue_ram.sv
pulse_queue_arbiter.sv
pulse_capture.sv
pulse_playout.sv
panda_pulse.sv
tb_panda_pulse.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_panda_pulse -f tb.f -o sim_tb
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/sim_tb
run_status=$?
if [ "$run_status" -ne 0 ]; then
    echo "Simulation failed with status $run_status"
    exit "$run_status"
fi

exit 0

// File: tb_panda_pulse.sv
// Directed testbench for panda_pulse, built with a depth-8 queue so overflow is reachable
// out_o, perr_o and queue_o are predicted every cycle from a model of the timing rules
// Inputs change on the falling edge; outputs are sampled there too

`timescale 1ns/100ps

module tb_panda_pulse;

    localparam int          QUEUE_AW    = 3;
    localparam int          DEPTH       = 1 << QUEUE_AW;
    localparam int          CLK_HALF    = 5;
    localparam int          RESET_CYC   = 4;
    localparam int          DRAIN_LIMIT = 200;
    localparam int unsigned RAND_SEED   = 32'h5d7d_d8e5;

    // Cycle budget of each test, with drain time
    localparam int SINGLE_CYC   = 40;
    localparam int SPACED_CYC   = 60;
    localparam int PERIOD_CYC   = 50;
    localparam int OVERFLOW_CYC = 160;
    localparam int RANDOM_CYC   = 400;
    localparam int FLUSH_CYC    = 120;
    localparam int TOTAL_CYC    = RESET_CYC + SINGLE_CYC + SPACED_CYC + PERIOD_CYC
                                + OVERFLOW_CYC + RANDOM_CYC + FLUSH_CYC;
    // Twice the budget in ns
    localparam int WATCHDOG_NS  = 2 * TOTAL_CYC * 2 * CLK_HALF;

    logic              clk_i = 1'b0;
    logic              reset_i;
    logic              inp_i;
    logic              rst_i;
    logic              force_rst_i;
    logic [47:0]       delay_i;
    logic [47:0]       width_i;
    logic              out_o;
    logic              perr_o;
    logic              err_overflow_o;
    logic              err_period_o;
    logic [QUEUE_AW:0] queue_o;
    logic [31:0]       missed_cnt_o;

    // Rising clock edges since time zero
    longint cycle = 0;

    // One model entry per accepted edge
    longint ent_e0[$];
    longint ent_start[$];
    longint ent_end[$];
    // Cycles where perr_o must be high
    longint drop_at[$];

    longint      cfg_delay;
    longint      cfg_width;
    longint      last_acc;
    logic        last_valid;
    logic        want_err_period;
    logic        want_err_ovf;
    int unsigned want_missed;

    always #(CLK_HALF) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    panda_pulse #(
        .QUEUE_AW (QUEUE_AW)
    ) u_dut (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .inp_i          (inp_i),
        .rst_i          (rst_i),
        .force_rst_i    (force_rst_i),
        .delay_i        (delay_i),
        .width_i        (width_i),
        .out_o          (out_o),
        .perr_o         (perr_o),
        .err_overflow_o (err_overflow_o),
        .err_period_o   (err_period_o),
        .queue_o        (queue_o),
        .missed_cnt_o   (missed_cnt_o)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            fail_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h at cycle %0d",
                               name, got, want, cycle));
        end
    endtask

    // High from E0+delay up to but not including E0+delay+width
    function automatic logic out_expected(input longint n);
        logic hit;
        hit = 1'b0;
        foreach (ent_start[i]) begin
            if (n >= ent_start[i] && n < ent_end[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // One cycle after a dropped edge
    function automatic logic perr_expected(input longint n);
        logic hit;
        hit = 1'b0;
        foreach (drop_at[i]) begin
            if (n == drop_at[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Entry counted from the write at E0+2 until its pulse falls
    function automatic int level_at(input longint n);
        int cnt;
        cnt = 0;
        foreach (ent_e0[i]) begin
            if (n >= ent_e0[i] + 2 && n < ent_end[i]) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    function automatic longint last_end();
        longint m;
        m = 0;
        foreach (ent_end[i]) begin
            if (ent_end[i] > m) begin
                m = ent_end[i];
            end
        end
        return m;
    endfunction

    // One clock, then compare the per-cycle outputs with the model
    task automatic advance();
        @(negedge clk_i);
        compare("out_o", 64'(out_o), 64'(out_expected(cycle)));
        compare("perr_o", 64'(perr_o), 64'(perr_expected(cycle)));
        compare("queue_o", 64'(queue_o), 64'(level_at(cycle)));
    endtask

    task automatic idle_for(input int n);
        repeat (n) advance();
    endtask

    task automatic check_status();
        compare("err_period_o", 64'(err_period_o), 64'(want_err_period));
        compare("err_overflow_o", 64'(err_overflow_o), 64'(want_err_ovf));
        compare("missed_cnt_o", 64'(missed_cnt_o), 64'(want_missed));
    endtask

    // Only while the queue is empty
    task automatic set_config(input longint d, input longint w);
        delay_i   = 48'(d);
        width_i   = 48'(w);
        cfg_delay = d;
        cfg_width = w;
    endtask

    // One-cycle high on inp_i; the next call comes two cycles later at the earliest
    task automatic send_edge();
        longint e0;
        advance();
        inp_i = 1'b1;
        e0 = cycle + 1;
        if (last_valid && (e0 - last_acc) <= cfg_width) begin
            drop_at.push_back(e0 + 1);
            want_err_period = 1'b1;
            want_missed++;
        end else if (level_at(e0) == DEPTH) begin
            drop_at.push_back(e0 + 1);
            want_err_ovf = 1'b1;
            want_missed++;
        end else begin
            ent_e0.push_back(e0);
            ent_start.push_back(e0 + cfg_delay);
            ent_end.push_back(e0 + cfg_delay + cfg_width);
            last_acc   = e0;
            last_valid = 1'b1;
        end
        advance();
        inp_i = 1'b0;
    endtask

    // Waits for an empty queue and a low output, bounded
    task automatic drain_queue();
        int waited;
        waited = 0;
        advance();
        while (queue_o != '0 || out_o || cycle < last_end()) begin
            if (waited >= DRAIN_LIMIT) begin
                fail_run("Queue did not drain within the cycle limit");
            end else begin
                advance();
                waited++;
            end
        end
    endtask

    task automatic soft_reset_pulse();
        advance();
        rst_i = 1'b1;
        // Queue empties and the pulse ends at the coming edge
        ent_e0.delete();
        ent_start.delete();
        ent_end.delete();
        last_valid = 1'b0;
        advance();
        rst_i = 1'b0;
    endtask

    task automatic force_reset_pulse();
        advance();
        force_rst_i = 1'b1;
        advance();
        force_rst_i = 1'b0;
        want_err_period = 1'b0;
        want_err_ovf    = 1'b0;
        want_missed     = 0;
    endtask

    task automatic single_edge_pulse();
        // Everything idle straight after reset
        compare("out_o", 64'(out_o), 64'(0));
        compare("perr_o", 64'(perr_o), 64'(0));
        compare("queue_o", 64'(queue_o), 64'(0));
        check_status();
        set_config(10, 3);
        send_edge();
        drain_queue();
        compare("queue_o", 64'(queue_o), 64'(0));
    endtask

    task automatic spaced_edges_play();
        set_config(12, 2);
        // Four ticks apart, wider than the width so all are kept
        repeat (6) begin
            send_edge();
            idle_for(2);
        end
        drain_queue();
        check_status();
    endtask

    task automatic period_drop_flags();
        set_config(10, 3);
        send_edge();
        // Two ticks later, inside the width
        send_edge();
        advance();
        compare("perr_o", 64'(perr_o), 64'(1));
        compare("missed_cnt_o", 64'(missed_cnt_o), 64'(1));
        check_status();
        drain_queue();
    endtask

    task automatic overflow_and_force_reset();
        set_config(100, 1);
        // Eight fill the queue, the ninth finds it full
        repeat (DEPTH + 1) send_edge();
        advance();
        compare("err_overflow_o", 64'(err_overflow_o), 64'(1));
        compare("missed_cnt_o", 64'(missed_cnt_o), 64'(2));
        check_status();
        force_reset_pulse();
        compare("err_period_o", 64'(err_period_o), 64'(0));
        compare("err_overflow_o", 64'(err_overflow_o), 64'(0));
        compare("missed_cnt_o", 64'(missed_cnt_o), 64'(0));
        drain_queue();
    endtask

    task automatic random_trains();
        longint d;
        longint w;
        int     edges;
        int     gap;
        for (int t = 0; t < 4; t++) begin
            d     = 6 + longint'($urandom % 7);
            w     = 1 + longint'($urandom % 4);
            edges = 5 + int'($urandom % 4);
            set_config(d, w);
            for (int e = 0; e < edges; e++) begin
                // Always past the width, at most six entries in flight
                gap = int'(w) + 1 + int'($urandom % 3);
                send_edge();
                idle_for(gap - 2);
            end
            drain_queue();
        end
        check_status();
    endtask

    task automatic soft_reset_flush();
        set_config(40, 2);
        send_edge();
        send_edge();
        idle_for(2);
        send_edge();
        idle_for(2);
        send_edge();
        idle_for(10);
        // Three queued, none started yet
        compare("queue_o", 64'(queue_o), 64'(3));
        compare("err_period_o", 64'(err_period_o), 64'(1));
        check_status();
        soft_reset_pulse();
        compare("queue_o", 64'(queue_o), 64'(0));
        // Past every start time that was queued
        idle_for(60);
        compare("missed_cnt_o", 64'(missed_cnt_o), 64'(1));
        check_status();
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_run("Watchdog expired before the tests completed");
    end

    initial begin
        reset_i         = 1'b1;
        inp_i           = 1'b0;
        rst_i           = 1'b0;
        force_rst_i     = 1'b0;
        delay_i         = 48'd10;
        width_i         = 48'd1;
        cfg_delay       = 10;
        cfg_width       = 1;
        last_acc        = 0;
        last_valid      = 1'b0;
        want_err_period = 1'b0;
        want_err_ovf    = 1'b0;
        want_missed     = 0;
        void'($urandom(RAND_SEED));
        repeat (RESET_CYC) @(negedge clk_i);
        reset_i = 1'b0;
        single_edge_pulse();
        spaced_edges_play();
        period_drop_flags();
        overflow_and_force_reset();
        random_trains();
        soft_reset_flush();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: panda_pulse.sv
// Pulse delay and stretch: each rising edge on inp_i gives a width_i pulse
// on out_o, delay_i ticks later
// Assumes width_i >= 1 and delay_i >= 6, changed only while the queue is empty
// rst_i empties the queue and ends any pulse, force_rst_i clears errors

`timescale 1ns/100ps

module panda_pulse import pulse_types_pkg::*; import pulse_mem_pkg::*; #(
    parameter int QUEUE_AW = QUEUE_AW_DEF
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              inp_i,
    input  logic              rst_i,
    input  logic              force_rst_i,
    input  logic [47:0]       delay_i,
    input  logic [47:0]       width_i,
    output logic              out_o,
    output logic              perr_o,
    output logic              err_overflow_o,
    output logic              err_period_o,
    output logic [QUEUE_AW:0] queue_o,
    output logic [31:0]       missed_cnt_o
);

    ts_t  tick;
    logic pop;

    // One queue link per peer
    pulse_mem_if #(.QUEUE_AW(QUEUE_AW)) cap_if ();
    pulse_mem_if #(.QUEUE_AW(QUEUE_AW)) play_if ();

    // Timestamps edges and decides accept or drop
    pulse_capture #(
        .QUEUE_AW (QUEUE_AW)
    ) u_capture (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .inp_i          (inp_i),
        .rst_i          (rst_i),
        .force_rst_i    (force_rst_i),
        .delay_i        (delay_i),
        .width_i        (width_i),
        .tick_o         (tick),
        .perr_o         (perr_o),
        .err_overflow_o (err_overflow_o),
        .err_period_o   (err_period_o),
        .missed_cnt_o   (missed_cnt_o),
        .mem            (cap_if.peer)
    );

    // Turns queued start times into pulses
    pulse_playout #(
        .QUEUE_AW (QUEUE_AW)
    ) u_playout (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .rst_i   (rst_i),
        .tick_i  (tick),
        .width_i (width_i),
        .out_o   (out_o),
        .pop_o   (pop),
        .mem     (play_if.peer)
    );

    // Queue RAM, pointers and fill count
    pulse_queue_arbiter #(
        .QUEUE_AW (QUEUE_AW)
    ) u_arbiter (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .rst_i   (rst_i),
        .pop_i   (pop),
        .cap     (cap_if.arb),
        .play    (play_if.arb),
        .level_o (queue_o)
    );

endmodule

// File: pulse_playout.sv
// Plays queued start times on out_o, one width_i pulse per entry
// Prefetches the following entry while one is waiting or high, so
// pulses one tick apart play back to back
// A start time already passed when fetched waits for the tick counter to wrap

`timescale 1ns/100ps

module pulse_playout import pulse_types_pkg::*; #(
    parameter int QUEUE_AW = 10
) (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      rst_i,
    input  ts_t       tick_i,
    input  ts_t       width_i,
    output logic      out_o,
    output logic      pop_o,
    pulse_mem_if.peer mem
);

    play_state_t state_q;
    ts_t         cur_q;
    ts_t         cnt_q;
    ts_t         nxt_q;
    logic        nxt_valid_q;
    logic        rd_pend_q;
    ts_t         tick_nx;
    ts_t         cand;
    logic        active;
    logic        have;
    logic        last_tick;
    logic        take;

    // Tick value after the coming edge
    assign tick_nx = tick_i + ts_t'(1);

    // An entry is held while waiting or high
    assign active = (state_q == PLAY_WAIT) || (state_q == PLAY_HIGH);

    // Next start time, from the prefetch slot or straight off the RAM
    // Slot and outstanding read never coexist
    assign have = nxt_valid_q | rd_pend_q;
    assign cand = nxt_valid_q ? nxt_q : mem.rdata;

    // Final high tick; the entry is popped at the falling edge
    assign last_tick = (state_q == PLAY_HIGH) && (cnt_q == ts_t'(1));
    assign pop_o     = last_tick;

    // Hand the next start time to the FSM
    assign take = have && ((state_q == PLAY_IDLE) || (state_q == PLAY_FETCH) || last_tick);

    // Read only when the queue holds more than the entry already playing
    assign mem.req   = ~have && (mem.level > {{QUEUE_AW{1'b0}}, active});
    assign mem.we    = 1'b0;
    assign mem.wdata = '0;

    always_ff @(posedge clk_i) begin
        if (reset_i || rst_i) begin
            state_q     <= PLAY_IDLE;
            out_o       <= 1'b0;
            nxt_valid_q <= 1'b0;
            rd_pend_q   <= 1'b0;
        end else begin
            rd_pend_q <= mem.gnt;
            if (take) begin
                nxt_valid_q <= 1'b0;
            end else if (rd_pend_q) begin
                nxt_valid_q <= 1'b1;
            end
            case (state_q)
                PLAY_IDLE, PLAY_FETCH: begin
                    if (take) begin
                        // Start may already be due on the next tick
                        if (cand == tick_nx) begin
                            state_q <= PLAY_HIGH;
                            out_o   <= 1'b1;
                        end else begin
                            state_q <= PLAY_WAIT;
                        end
                    end else if (mem.gnt) begin
                        state_q <= PLAY_FETCH;
                    end
                end
                PLAY_WAIT: begin
                    if (cur_q == tick_nx) begin
                        state_q <= PLAY_HIGH;
                        out_o   <= 1'b1;
                    end
                end
                PLAY_HIGH: begin
                    if (last_tick) begin
                        out_o <= 1'b0;
                        // Next entry starts at least one tick after this fall
                        state_q <= take ? PLAY_WAIT : PLAY_IDLE;
                    end
                end
                default: begin
                    state_q <= PLAY_IDLE;
                end
            endcase
        end
    end

    // Start times and width countdown
    always_ff @(posedge clk_i) begin
        if (rd_pend_q && !take) begin
            nxt_q <= mem.rdata;
        end
        if (take) begin
            cur_q <= cand;
        end
        // Loaded while not high so the count is ready at the rise
        if (state_q == PLAY_HIGH) begin
            cnt_q <= cnt_q - ts_t'(1);
        end else begin
            cnt_q <= width_i;
        end
    end

endmodule

// File: pulse_capture.sv
// Rising-edge capture against a free-running 48-bit tick counter
// An edge needs a low sample before it, so writes come at most every 2 cycles
// Decisions and error flags register one cycle after the edge is sampled
// Error flags and the missed count survive rst_i, only force_rst_i clears them

`timescale 1ns/100ps

module pulse_capture import pulse_types_pkg::*; #(
    parameter int QUEUE_AW = 10
) (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      inp_i,
    input  logic      rst_i,
    input  logic      force_rst_i,
    input  ts_t       delay_i,
    input  ts_t       width_i,
    output ts_t       tick_o,
    output logic      perr_o,
    output logic      err_overflow_o,
    output logic      err_period_o,
    output miss_cnt_t missed_cnt_o,
    pulse_mem_if.peer mem
);

    // Full queue as a fill count
    localparam logic [QUEUE_AW:0] DEPTH = {1'b1, {QUEUE_AW{1'b0}}};

    ts_t  tick_q;
    logic inp_q;
    logic inp_q2;
    ts_t  last_ts_q;
    logic last_valid_q;
    logic req_q;
    ts_t  start_q;
    ts_t  delay_eff;
    logic rise;
    logic period_drop;
    logic ovf_drop;
    logic accept;

    // Edge seen on the registered copy, one cycle behind inp_i
    assign rise = inp_q & ~inp_q2;

    // Short delays are stretched to what the fetch path can meet
    assign delay_eff = (delay_i < DELAY_MIN) ? DELAY_MIN : delay_i;

    // Too close to the last accepted edge, pulses would overlap
    assign period_drop = rise & last_valid_q & ((tick_q - last_ts_q) <= width_i);
    assign ovf_drop    = rise & ~period_drop & (mem.level == DEPTH);
    assign accept      = rise & ~period_drop & ~ovf_drop & ~rst_i;

    // Free-running tick and input sampling
    // Input regs start high so a level already high at reset is no edge
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tick_q <= '0;
            inp_q  <= 1'b1;
            inp_q2 <= 1'b1;
        end else begin
            tick_q <= tick_q + ts_t'(1);
            inp_q  <= inp_i;
            inp_q2 <= inp_q;
        end
    end

    // Accepted-edge tracking, write request, errors
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            last_valid_q   <= 1'b0;
            req_q          <= 1'b0;
            perr_o         <= 1'b0;
            err_period_o   <= 1'b0;
            err_overflow_o <= 1'b0;
            missed_cnt_o   <= '0;
        end else begin
            perr_o <= period_drop | ovf_drop;
            if (rst_i) begin
                last_valid_q <= 1'b0;
                req_q        <= 1'b0;
            end else if (accept) begin
                last_valid_q <= 1'b1;
                req_q        <= 1'b1;
            end else if (mem.gnt) begin
                req_q <= 1'b0;
            end
            // A new error wins over force_rst_i in the same cycle
            if (period_drop) begin
                err_period_o <= 1'b1;
            end else if (force_rst_i) begin
                err_period_o <= 1'b0;
            end
            if (ovf_drop) begin
                err_overflow_o <= 1'b1;
            end else if (force_rst_i) begin
                err_overflow_o <= 1'b0;
            end
            if (period_drop | ovf_drop) begin
                missed_cnt_o <= force_rst_i ? miss_cnt_t'(1) : missed_cnt_o + miss_cnt_t'(1);
            end else if (force_rst_i) begin
                missed_cnt_o <= '0;
            end
        end
    end

    // Edge timestamp and output start time
    always_ff @(posedge clk_i) begin
        if (accept) begin
            last_ts_q <= tick_q;
            start_q   <= tick_q + delay_eff;
        end
    end

    assign tick_o    = tick_q;
    assign mem.req   = req_q;
    assign mem.we    = 1'b1;
    assign mem.wdata = start_q;

endmodule

// File: pulse_queue_arbiter.sv
// Shares the single RAM port between capture and playout
// Capture has fixed priority; playout waits at most one cycle
// Grants are combinational, pointers and fill count move on the granting edge
// Capture must not write when full, the arbiter does not check

`timescale 1ns/100ps

module pulse_queue_arbiter import pulse_types_pkg::*; import pulse_mem_pkg::*; #(
    parameter int QUEUE_AW = 10
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              rst_i,
    input  logic              pop_i,
    pulse_mem_if.arb          cap,
    pulse_mem_if.arb          play,
    output logic [QUEUE_AW:0] level_o
);

    localparam logic [QUEUE_AW-1:0] PTR_ONE = {{(QUEUE_AW-1){1'b0}}, 1'b1};
    localparam logic [QUEUE_AW:0]   LVL_ONE = {{QUEUE_AW{1'b0}}, 1'b1};

    logic [QUEUE_AW-1:0] head_q;
    logic [QUEUE_AW-1:0] tail_q;
    logic [QUEUE_AW:0]   count_q;
    mem_owner_t          owner_d;
    mem_owner_t          owner_q;
    logic                ram_we;
    logic [QUEUE_AW-1:0] ram_addr;
    ts_t                 ram_wdata;
    ts_t                 ram_rdata;
    logic                wr_fire;
    logic                rd_fire;

    // Fixed priority, nothing granted during a soft reset
    always_comb begin
        owner_d = OWN_NONE;
        if (!rst_i) begin
            if (cap.req) begin
                owner_d = OWN_CAPTURE;
            end else if (play.req) begin
                owner_d = OWN_PLAYOUT;
            end
        end
    end

    assign cap.gnt  = (owner_d == OWN_CAPTURE);
    assign play.gnt = (owner_d == OWN_PLAYOUT);

    // RAM port mux, writes to the tail, reads from the head
    always_comb begin
        ram_we    = 1'b0;
        ram_wdata = cap.wdata;
        case (owner_d)
            OWN_CAPTURE: begin
                ram_we    = cap.we;
                ram_wdata = cap.wdata;
            end
            OWN_PLAYOUT: begin
                ram_we    = play.we;
                ram_wdata = play.wdata;
            end
            default: begin
                ram_we = 1'b0;
            end
        endcase
        ram_addr = ram_we ? tail_q : head_q;
    end

    assign wr_fire = (owner_d != OWN_NONE) && ram_we;
    assign rd_fire = (owner_d != OWN_NONE) && !ram_we;

    // head moves on a read, the fill count only drops on pop
    always_ff @(posedge clk_i) begin
        if (reset_i || rst_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= owner_d;
            if (wr_fire) begin
                tail_q <= tail_q + PTR_ONE;
            end
            if (rd_fire) begin
                head_q <= head_q + PTR_ONE;
            end
            case ({wr_fire, pop_i})
                2'b10:   count_q <= count_q + LVL_ONE;
                2'b01:   count_q <= count_q - LVL_ONE;
                default: count_q <= count_q;
            endcase
        end
    end

    // Read data goes back only to last cycle's owner
    assign cap.rdata  = (owner_q == OWN_CAPTURE) ? ram_rdata : '0;
    assign play.rdata = (owner_q == OWN_PLAYOUT) ? ram_rdata : '0;

    assign cap.level  = count_q;
    assign play.level = count_q;
    assign level_o    = count_q;

    pulse_queue_ram #(
        .QUEUE_AW (QUEUE_AW)
    ) u_ram (
        .clk_i   (clk_i),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

// File: pulse_queue_ram.sv
// Single-port RAM of 2**QUEUE_AW start times, registered read
// Read-before-write on the same address; contents are not reset

`timescale 1ns/100ps

module pulse_queue_ram import pulse_types_pkg::*; #(
    parameter int QUEUE_AW = 10
) (
    input  logic                clk_i,
    input  logic                we_i,
    input  logic [QUEUE_AW-1:0] addr_i,
    input  ts_t                 wdata_i,
    output ts_t                 rdata_o
);

    ts_t ram_q [0:(1 << QUEUE_AW)-1];

    // One access per cycle, data out one cycle after the address
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            ram_q[addr_i] <= wdata_i;
        end
        rdata_o <= ram_q[addr_i];
    end

endmodule

// File: pulse_mem_if.sv
// One peer's access to the start-time queue
// req is held until gnt, gnt lasts one cycle
// Read data is valid in the cycle after gnt; writes always go to the tail
// level is the fill count and counts entries until they are popped

`timescale 1ns/100ps

interface pulse_mem_if import pulse_types_pkg::*; #(
    parameter int QUEUE_AW = 10
) ();

    // Peer side
    logic req;
    logic we;
    ts_t  wdata;

    // Arbiter side
    logic              gnt;
    ts_t               rdata;
    logic [QUEUE_AW:0] level;

    // Capture or playout
    modport peer (
        output req, we, wdata,
        input  gnt, rdata, level
    );

    // Queue arbiter
    modport arb (
        input  req, we, wdata,
        output gnt, rdata, level
    );

endinterface

// File: pulse_mem_pkg.sv
// Queue-side definitions for the start-time RAM and its arbiter
// A queue of 2**QUEUE_AW entries reports its fill on QUEUE_AW+1 bits
// Only one peer owns the single RAM port in any cycle

package pulse_mem_pkg;

    // Default address width, giving 1024 queued start times
    localparam int QUEUE_AW_DEF = 10;

    // Peer granted the RAM port
    // Registered for one cycle so read data goes back to the requester
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_CAPTURE,
        OWN_PLAYOUT
    } mem_owner_t;

endpackage

// File: pulse_types_pkg.sv
// Tick and configuration types shared across the pulse delay block
// All tick quantities are 48-bit and wrap silently, with no wrap detection
// Delays below DELAY_MIN are raised to DELAY_MIN on the capture side

package pulse_types_pkg;

    // Width of the free-running tick counter and every tick quantity
    localparam int TS_W = 48;

    // Tick value
    // Used for timestamps, queued start times, delay and width
    typedef logic [TS_W-1:0] ts_t;

    // Missed-edge count as reported on the status port
    typedef logic [31:0] miss_cnt_t;

    // Shortest delay that the queue write and fetch path can honour
    // Two cycles to write, up to three more to fetch the head entry
    localparam ts_t DELAY_MIN = ts_t'(6);

    // Playout FSM, one pass per queued entry
    // IDLE   nothing held, read requested when the queue has unread data
    // FETCH  read granted, head data arrives this cycle
    // WAIT   start time known, waiting for the tick counter
    // HIGH   output asserted, counting down the width
    typedef enum logic [1:0] {
        PLAY_IDLE,
        PLAY_FETCH,
        PLAY_WAIT,
        PLAY_HIGH
    } play_state_t;

endpackage
